// ==== hdl/wb_pkg.sv ====
/*
 * Write-back subsystem package
 * Shared widths and limits for the EX/WB register, the LSU response
 * tracker, the write-back stage and the register file
 */

`default_nettype none

package wb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////////////////////////

  // Register address width, x0..x31
  localparam int unsigned REG_ADDR_W = 5;
  // Data path width
  localparam int unsigned XLEN = 32;
  // Number of architectural registers
  localparam int unsigned NUM_REGS = 32;

  //////////////////////////////////////////////////////////////////////
  // Data bus limits
  //////////////////////////////////////////////////////////////////////

  // Loads allowed between request and response
  localparam int unsigned LSU_MAX_OUTSTANDING = 2;
  // Counter must hold 0..LSU_MAX_OUTSTANDING inclusive
  localparam int unsigned LSU_CNT_W = $clog2(LSU_MAX_OUTSTANDING + 1);

endpackage

`default_nettype wire

// ==== hdl/ex_wb_pipe_reg.sv ====
/*
 * EX/WB pipeline register
 * Holds the write-back fields of one instruction between the execute
 * and write-back stages. Advances when write-back is ready; the valid
 * bit drops when advancing without a new instruction
 */

`default_nettype none

module ex_wb_pipe_reg
  import wb_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,

  // Write-back side is done with its current instruction
  input  wire logic                  advance_i,

  // Execute side fields, ex_valid_i already qualified by acceptance
  input  wire logic                  ex_valid_i,
  input  wire logic                  ex_rf_we_i,
  input  wire logic                  ex_lsu_en_i,
  input  wire logic [REG_ADDR_W-1:0] ex_rf_waddr_i,
  input  wire logic [XLEN-1:0]       ex_rf_wdata_i,

  // Held fields toward write-back
  output logic                       instr_valid_o,
  output logic                       rf_we_o,
  output logic                       lsu_en_o,
  output logic [REG_ADDR_W-1:0]      rf_waddr_o,
  output logic [XLEN-1:0]            rf_wdata_o
);

  logic                  instr_valid_q;
  logic                  rf_we_q;
  logic                  lsu_en_q;
  logic [REG_ADDR_W-1:0] rf_waddr_q;
  logic [XLEN-1:0]       rf_wdata_q;

  //////////////////////////////////////////////////////////////////////
  // Valid bit
  //////////////////////////////////////////////////////////////////////

  // Only control state sees reset, register starts empty
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      instr_valid_q <= 1'b0;
    end else if (advance_i) begin
      // Bubble enters when execute offers nothing
      instr_valid_q <= ex_valid_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  // Fields only load with a real instruction, bubbles leave them alone
  always_ff @(posedge clk) begin
    if (advance_i && ex_valid_i) begin
      rf_we_q    <= ex_rf_we_i;
      lsu_en_q   <= ex_lsu_en_i;
      rf_waddr_q <= ex_rf_waddr_i;
      rf_wdata_q <= ex_rf_wdata_i;
    end
  end

  assign instr_valid_o = instr_valid_q;
  assign rf_we_o       = rf_we_q;
  assign lsu_en_o      = lsu_en_q;
  assign rf_waddr_o    = rf_waddr_q;
  assign rf_wdata_o    = rf_wdata_q;

endmodule

`default_nettype wire

// ==== hdl/lsu_resp.sv ====
/*
 * LSU response tracker
 * Counts data-bus loads between request and response, reports room
 * for another load, drives the request pulse and presents each bus
 * response to the write-back stage
 */

`default_nettype none

module lsu_resp
  import wb_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n_i,

  // A load is being accepted from execute this cycle
  input  wire logic load_issue_i,

  // Data bus response strobe
  input  wire logic data_rvalid_i,

  // Another load may be issued
  output logic      room_o,

  // Data bus request pulse
  output logic      data_req_o,

  // Response present for write-back this cycle
  output logic      resp_valid_o
);

  // Limit at counter width, for comparison
  localparam logic [LSU_CNT_W-1:0] MAX_CNT = LSU_CNT_W'(LSU_MAX_OUTSTANDING);

  logic [LSU_CNT_W-1:0] cnt_q;
  logic [LSU_CNT_W-1:0] cnt_nxt;
  logic                 cnt_inc;
  logic                 cnt_dec;

  //////////////////////////////////////////////////////////////////////
  // Request and response strobes
  //////////////////////////////////////////////////////////////////////

  // Below the limit a new load can go out
  assign room_o = (cnt_q < MAX_CNT);

  // Request fires in the accepting cycle only
  assign data_req_o = load_issue_i;

  // A response with nothing outstanding is ignored
  assign resp_valid_o = data_rvalid_i && (cnt_q != '0);

  assign cnt_inc = data_req_o;
  assign cnt_dec = resp_valid_o;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_nxt = cnt_q;
    // Request and response in the same cycle cancel out
    if (cnt_inc && !cnt_dec) begin
      cnt_nxt = cnt_q + 1'b1;
    end else if (cnt_dec && !cnt_inc) begin
      cnt_nxt = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wb_stage.sv ====
/*
 * Write-back stage
 * Qualifies the held instruction with kill and halt, selects load or
 * execute data for the register write and produces stage ready and
 * the valid strobe of the final write. Purely combinational
 */

`default_nettype none

module wb_stage
  import wb_pkg::*;
(
  // EX/WB register contents
  input  wire logic                  instr_valid_i,
  input  wire logic                  rf_we_i,
  input  wire logic                  lsu_en_i,
  input  wire logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  wire logic [XLEN-1:0]       rf_wdata_i,

  // Controller levels
  input  wire logic                  kill_wb_i,
  input  wire logic                  halt_wb_i,

  // Load data and response strobe
  input  wire logic [XLEN-1:0]       lsu_rdata_i,
  input  wire logic                  lsu_valid_i,

  // Register file write port
  output logic                       rf_we_wb_o,
  output logic [REG_ADDR_W-1:0]      rf_waddr_wb_o,
  output logic [XLEN-1:0]            rf_wdata_wb_o,

  // Stage status
  output logic                       lsu_en_wb_o,
  output logic                       wb_ready_o,
  output logic                       wb_valid_o
);

  logic instr_valid;
  logic result_ready;

  // Held instruction with all disqualifiers applied
  assign instr_valid = instr_valid_i && !kill_wb_i && !halt_wb_i;

  // Load in flight in write-back, a kill here is illegal
  assign lsu_en_wb_o = lsu_en_i && instr_valid;

  //////////////////////////////////////////////////////////////////////
  // Register file write
  //////////////////////////////////////////////////////////////////////

  // Waiting loads write stale bus data each cycle
  // only the wb_valid_o cycle counts
  assign rf_we_wb_o    = rf_we_i && instr_valid;
  assign rf_waddr_wb_o = rf_waddr_i;
  assign rf_wdata_wb_o = lsu_en_i ? lsu_rdata_i : rf_wdata_i;

  //////////////////////////////////////////////////////////////////////
  // Stage ready / valid
  //////////////////////////////////////////////////////////////////////

  // Non-loads finish at once, loads need the bus response
  assign result_ready = !lsu_en_i || lsu_valid_i;

  // Empty or killed always moves on; halt freezes a live instruction
  assign wb_ready_o = !instr_valid_i || kill_wb_i || (!halt_wb_i && result_ready);

  // Marks the architecturally final write
  assign wb_valid_o = instr_valid && result_ready;

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
/*
 * Register file
 * NUM_REGS x XLEN array with one write port and one combinational
 * read port. Cleared on reset; writes to x0 are dropped
 */

`default_nettype none

module reg_file
  import wb_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,

  // Write port
  input  wire logic                  we_i,
  input  wire logic [REG_ADDR_W-1:0] waddr_i,
  input  wire logic [XLEN-1:0]       wdata_i,

  // Read port
  input  wire logic [REG_ADDR_W-1:0] raddr_i,
  output logic [XLEN-1:0]            rdata_o
);

  logic [XLEN-1:0] regs_q [NUM_REGS];
  logic            wr_en;

  // x0 is hardwired, never store into it
  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Read straight from the array
  // x0 stays at its reset value of zero
  assign rdata_o = regs_q[raddr_i];

endmodule

`default_nettype wire

// ==== hdl/wb_top.sv ====
/*
 * Write-back subsystem top
 * EX/WB pipeline register, LSU response tracker, write-back stage and
 * register file. Forms the accept, advance and ex_ready gating and
 * exposes the register-file write port
 */

`default_nettype none

module wb_top
  import wb_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,

  // Execute side
  input  wire logic                  ex_valid_i,
  input  wire logic                  ex_rf_we_i,
  input  wire logic [REG_ADDR_W-1:0] ex_rf_waddr_i,
  input  wire logic [XLEN-1:0]       ex_rf_wdata_i,
  input  wire logic                  ex_lsu_en_i,
  output logic                       ex_ready_o,

  // Controller levels
  input  wire logic                  kill_wb_i,
  input  wire logic                  halt_wb_i,

  // Data bus
  output logic                       data_req_o,
  input  wire logic                  data_rvalid_i,
  input  wire logic [XLEN-1:0]       data_rdata_i,

  // Register file write port copies
  output logic                       rf_we_o,
  output logic [REG_ADDR_W-1:0]      rf_waddr_o,
  output logic [XLEN-1:0]            rf_wdata_o,

  // Write-back status
  output logic                       wb_valid_o,
  output logic                       lsu_en_wb_o,

  // Register read port
  input  wire logic [REG_ADDR_W-1:0] rs_addr_i,
  output logic [XLEN-1:0]            rs_rdata_o
);

  logic                  ex_accept;
  logic                  load_issue;
  logic                  wb_ready;
  logic                  lsu_room;
  logic                  lsu_resp_valid;
  logic                  pipe_valid;
  logic                  pipe_rf_we;
  logic                  pipe_lsu_en;
  logic [REG_ADDR_W-1:0] pipe_rf_waddr;
  logic [XLEN-1:0]       pipe_rf_wdata;

  //////////////////////////////////////////////////////////////////////
  // Handshake with execute
  //////////////////////////////////////////////////////////////////////

  // Loads also need a free slot in the tracker
  assign ex_ready_o = wb_ready && (!ex_lsu_en_i || lsu_room);
  assign ex_accept  = ex_valid_i && ex_ready_o;
  assign load_issue = ex_accept && ex_lsu_en_i;

  // Advance on wb_ready alone so a finished instruction never lingers
  ex_wb_pipe_reg u_ex_wb_pipe_reg (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .advance_i     (wb_ready),
    .ex_valid_i    (ex_accept),
    .ex_rf_we_i    (ex_rf_we_i),
    .ex_lsu_en_i   (ex_lsu_en_i),
    .ex_rf_waddr_i (ex_rf_waddr_i),
    .ex_rf_wdata_i (ex_rf_wdata_i),
    .instr_valid_o (pipe_valid),
    .rf_we_o       (pipe_rf_we),
    .lsu_en_o      (pipe_lsu_en),
    .rf_waddr_o    (pipe_rf_waddr),
    .rf_wdata_o    (pipe_rf_wdata)
  );

  lsu_resp u_lsu_resp (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .load_issue_i  (load_issue),
    .data_rvalid_i (data_rvalid_i),
    .room_o        (lsu_room),
    .data_req_o    (data_req_o),
    .resp_valid_o  (lsu_resp_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Write-back and register file
  //////////////////////////////////////////////////////////////////////

  wb_stage u_wb_stage (
    .instr_valid_i (pipe_valid),
    .rf_we_i       (pipe_rf_we),
    .lsu_en_i      (pipe_lsu_en),
    .rf_waddr_i    (pipe_rf_waddr),
    .rf_wdata_i    (pipe_rf_wdata),
    .kill_wb_i     (kill_wb_i),
    .halt_wb_i     (halt_wb_i),
    .lsu_rdata_i   (data_rdata_i),
    .lsu_valid_i   (lsu_resp_valid),
    .rf_we_wb_o    (rf_we_o),
    .rf_waddr_wb_o (rf_waddr_o),
    .rf_wdata_wb_o (rf_wdata_o),
    .lsu_en_wb_o   (lsu_en_wb_o),
    .wb_ready_o    (wb_ready),
    .wb_valid_o    (wb_valid_o)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .we_i    (rf_we_o),
    .waddr_i (rf_waddr_o),
    .wdata_i (rf_wdata_o),
    .raddr_i (rs_addr_i),
    .rdata_o (rs_rdata_o)
  );

endmodule

`default_nettype wire

// ==== tb/wb_top_sva.sv ====
/*
 * Write-back control assertions
 * Bound into wb_top, watches kill, halt and the data-bus request
 */

`default_nettype none

module wb_top_sva
  import wb_pkg::*;
(
  input wire logic                  clk,
  input wire logic                  rst_n_i,
  input wire logic                  kill_wb_i,
  input wire logic                  halt_wb_i,
  input wire logic                  pipe_valid_i,
  input wire logic                  pipe_lsu_en_i,
  input wire logic                  resp_valid_i,
  input wire logic                  data_req_i,
  input wire logic                  ex_ready_i,
  input wire logic [REG_ADDR_W-1:0] rf_waddr_i
);

  // A load in write-back is waiting on the bus and cannot be dropped
  kill_no_load : assert property (@(posedge clk) disable iff (!rst_n_i)
    kill_wb_i |-> !(pipe_valid_i && pipe_lsu_en_i))
    else $error("kill asserted while a load sits in write-back");

  // Request only goes out with an accepted load
  // and never past a load still waiting on its response
  req_needs_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
    data_req_i |-> (ex_ready_i && (!(pipe_valid_i && pipe_lsu_en_i) || resp_valid_i)))
    else $error("data_req_o high without room in write-back");

  // Halt keeps the held instruction in write-back
  halt_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
    (halt_wb_i && pipe_valid_i && !kill_wb_i) |=> (pipe_valid_i && $stable(rf_waddr_i)))
    else $error("held instruction left write-back during halt");

endmodule

bind wb_top wb_top_sva u_wb_top_sva (
  .clk           (clk),
  .rst_n_i       (rst_n_i),
  .kill_wb_i     (kill_wb_i),
  .halt_wb_i     (halt_wb_i),
  .pipe_valid_i  (pipe_valid),
  .pipe_lsu_en_i (pipe_lsu_en),
  .resp_valid_i  (lsu_resp_valid),
  .data_req_i    (data_req_o),
  .ex_ready_i    (ex_ready_o),
  .rf_waddr_i    (rf_waddr_o)
);

`default_nettype wire

// ==== tb/wb_checker.sv ====
/*
 * Write-back checker
 * Watches the DUT ports at the rising edge, keeps the accepted
 * instructions, the bus responses and a model register array, and
 * reports mismatches, one line per test and a closing summary
 */

`default_nettype none

module wb_checker
  import wb_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n_i,
  input  wire logic                  ex_valid_i,
  input  wire logic                  ex_rf_we_i,
  input  wire logic [REG_ADDR_W-1:0] ex_rf_waddr_i,
  input  wire logic [XLEN-1:0]       ex_rf_wdata_i,
  input  wire logic                  ex_lsu_en_i,
  input  wire logic                  ex_ready_i,
  input  wire logic                  kill_wb_i,
  input  wire logic                  halt_wb_i,
  input  wire logic                  data_req_i,
  input  wire logic                  data_rvalid_i,
  input  wire logic [XLEN-1:0]       data_rdata_i,
  input  wire logic                  rf_we_i,
  input  wire logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  wire logic [XLEN-1:0]       rf_wdata_i,
  input  wire logic                  wb_valid_i,
  input  wire logic                  lsu_en_wb_i,
  input  wire logic [REG_ADDR_W-1:0] rs_addr_i,
  input  wire logic [XLEN-1:0]       rs_rdata_i,
  // Test sequencing from the testbench top
  input  int                         test_id_i,
  input  wire logic                  test_end_i,
  input  wire logic                  readback_i,
  input  wire logic                  run_done_i,
  output int                         err_cnt_o
);

  typedef struct packed {
    logic                  we;
    logic                  load;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } instr_t;

  instr_t          pend_q[$];
  logic [XLEN-1:0] resp_q[$];
  logic [XLEN-1:0] model_regs [NUM_REGS];
  int              outstanding;
  int              test_errs;
  int              tests_passed;
  int              tests_failed;

  function automatic string test_name(input int id);
    case (id)
      1:       return "nonload_writes";
      2:       return "load_writes";
      3:       return "halt_hold";
      4:       return "kill_drop";
      5:       return "outstanding_limit";
      6:       return "regfile_readback";
      default: return "startup";
    endcase
  endfunction

  task automatic flag_value(input string what, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    $display("error %s: %s expected 0x%08h actual 0x%08h", test_name(test_id_i), what, exp, act);
    test_errs++;
    err_cnt_o++;
  endtask

  task automatic flag_event(input string what);
    $display("error %s: %s", test_name(test_id_i), what);
    test_errs++;
    err_cnt_o++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle comparison
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    instr_t          head;
    instr_t          acc;
    logic [XLEN-1:0] exp_data;
    logic            exp_req;
    logic            exp_lsu;
    if (!rst_n_i) begin
      pend_q.delete();
      resp_q.delete();
      for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
      end
      outstanding  = 0;
      test_errs    = 0;
      tests_passed = 0;
      tests_failed = 0;
      err_cnt_o    = 0;
    end else begin
      // Data bus request rules
      exp_req = ex_valid_i && ex_ready_i && ex_lsu_en_i;
      if (data_req_i !== exp_req) begin
        flag_value("data_req_o", XLEN'(exp_req), XLEN'(data_req_i));
      end
      if (data_req_i && outstanding == LSU_MAX_OUTSTANDING) begin
        flag_event("request issued with the outstanding limit reached");
      end
      if (data_rvalid_i) begin
        resp_q.push_back(data_rdata_i);
      end
      // Load marker follows the live instruction in write-back
      exp_lsu = (pend_q.size() != 0) && pend_q[0].load && !kill_wb_i && !halt_wb_i;
      if (lsu_en_wb_i !== exp_lsu) begin
        flag_value("lsu_en_wb_o", XLEN'(exp_lsu), XLEN'(lsu_en_wb_i));
      end
      // Halt freezes writes and execute handshake
      if (halt_wb_i) begin
        if (rf_we_i) flag_event("register write during halt");
        if (wb_valid_i) flag_event("write-back completed during halt");
        if (pend_q.size() != 0 && !kill_wb_i && ex_ready_i) begin
          flag_event("execute accepted while a halted instruction is held");
        end
      end
      if (kill_wb_i && wb_valid_i) flag_event("write-back completed while killed");
      // Final write of the oldest accepted instruction
      if (wb_valid_i) begin
        if (pend_q.size() == 0) begin
          flag_event("write-back completed with no instruction accepted");
        end else begin
          head     = pend_q.pop_front();
          exp_data = head.data;
          if (head.load && resp_q.size() == 0) begin
            flag_event("load completed without a bus response");
          end else if (head.load) begin
            exp_data = resp_q.pop_front();
          end
          if (rf_we_i !== head.we) flag_value("rf_we_o", XLEN'(head.we), XLEN'(rf_we_i));
          if (head.we) begin
            if (rf_waddr_i !== head.addr) begin
              flag_value("rf_waddr_o", XLEN'(head.addr), XLEN'(rf_waddr_i));
            end
            if (rf_wdata_i !== exp_data) flag_value("rf_wdata_o", exp_data, rf_wdata_i);
            if (head.addr != '0) model_regs[head.addr] = exp_data;
          end
        end
      end else if (kill_wb_i && pend_q.size() != 0) begin
        // Killed instruction leaves the model untouched
        head = pend_q.pop_front();
        if (head.load) flag_event("load killed in write-back");
        if (rf_we_i) flag_event("register write from a killed instruction");
      end
      if (ex_valid_i && ex_ready_i) begin
        acc.we   = ex_rf_we_i;
        acc.load = ex_lsu_en_i;
        acc.addr = ex_rf_waddr_i;
        acc.data = ex_rf_wdata_i;
        pend_q.push_back(acc);
      end
      outstanding = outstanding + int'(data_req_i)
                    - ((data_rvalid_i && outstanding != 0) ? 1 : 0);
      // Register file sweep, x0 must read zero
      if (readback_i) begin
        exp_data = (rs_addr_i == '0) ? '0 : model_regs[rs_addr_i];
        if (rs_rdata_i !== exp_data) flag_value("rs_rdata_o", exp_data, rs_rdata_i);
      end
      if (test_end_i) begin
        $display("test %0d %s: %s with %0d errors", test_id_i, test_name(test_id_i),
                 (test_errs == 0) ? "pass" : "FAIL", test_errs);
        if (test_errs == 0) tests_passed++;
        else tests_failed++;
        test_errs = 0;
      end
      if (run_done_i) begin
        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_cnt_o);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/wb_tb.sv ====
/*
 * Write-back subsystem testbench
 * Clock, reset, seeded random execute traffic with halt and kill,
 * an in-order data-bus responder and the run timeout
 */

`default_nettype none

module wb_tb
  import wb_pkg::*;
();

  localparam logic [31:0] SEED            = 32'hd96b_0e8a;
  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 400;
  localparam int          TIMEOUT_CYCLES  = CYCLES_PER_TEST * NUM_TESTS;
  localparam int          OPS_PER_TEST    = 60;

  logic                  clk;
  logic                  rst_n;
  logic                  ex_valid;
  logic                  ex_rf_we;
  logic [REG_ADDR_W-1:0] ex_rf_waddr;
  logic [XLEN-1:0]       ex_rf_wdata;
  logic                  ex_lsu_en;
  logic                  ex_ready;
  logic                  kill_wb;
  logic                  halt_wb;
  logic                  data_req;
  logic                  data_rvalid;
  logic [XLEN-1:0]       data_rdata;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  logic                  wb_valid;
  logic                  lsu_en_wb;
  logic [REG_ADDR_W-1:0] rs_addr;
  logic [XLEN-1:0]       rs_rdata;

  int   test_id;
  logic test_end;
  logic readback;
  logic run_done;
  int   err_cnt;
  int   cycle_cnt = 0;
  // Own record of the write-back slot, for legal kills
  logic slot_valid;
  logic slot_load;
  // Remaining delay of each outstanding bus request, oldest first
  int   bus_wait_q[$];

  wb_top DUT (
    .clk (clk), .rst_n_i (rst_n),
    .ex_valid_i (ex_valid), .ex_rf_we_i (ex_rf_we), .ex_rf_waddr_i (ex_rf_waddr),
    .ex_rf_wdata_i (ex_rf_wdata), .ex_lsu_en_i (ex_lsu_en), .ex_ready_o (ex_ready),
    .kill_wb_i (kill_wb), .halt_wb_i (halt_wb),
    .data_req_o (data_req), .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata),
    .rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata),
    .wb_valid_o (wb_valid), .lsu_en_wb_o (lsu_en_wb),
    .rs_addr_i (rs_addr), .rs_rdata_o (rs_rdata)
  );

  wb_checker u_checker (
    .clk (clk), .rst_n_i (rst_n),
    .ex_valid_i (ex_valid), .ex_rf_we_i (ex_rf_we), .ex_rf_waddr_i (ex_rf_waddr),
    .ex_rf_wdata_i (ex_rf_wdata), .ex_lsu_en_i (ex_lsu_en), .ex_ready_i (ex_ready),
    .kill_wb_i (kill_wb), .halt_wb_i (halt_wb),
    .data_req_i (data_req), .data_rvalid_i (data_rvalid), .data_rdata_i (data_rdata),
    .rf_we_i (rf_we), .rf_waddr_i (rf_waddr), .rf_wdata_i (rf_wdata),
    .wb_valid_i (wb_valid), .lsu_en_wb_i (lsu_en_wb),
    .rs_addr_i (rs_addr), .rs_rdata_i (rs_rdata),
    .test_id_i (test_id), .test_end_i (test_end), .readback_i (readback),
    .run_done_i (run_done), .err_cnt_o (err_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Slot record and bus request capture
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      slot_valid = 1'b0;
      slot_load  = 1'b0;
      bus_wait_q.delete();
    end else begin
      if (wb_valid || (kill_wb && slot_valid)) slot_valid = 1'b0;
      if (ex_valid && ex_ready) begin
        slot_valid = 1'b1;
        slot_load  = ex_lsu_en;
      end
      if (data_req) bus_wait_q.push_back(int'($urandom_range(3)));
    end
  end

  // In-order responder, never answers during halt
  task automatic step_bus();
    data_rvalid = 1'b0;
    data_rdata  = $urandom;
    if (bus_wait_q.size() != 0) begin
      if (bus_wait_q[0] > 0) begin
        bus_wait_q[0] = bus_wait_q[0] - 1;
      end else if (!halt_wb) begin
        data_rvalid = 1'b1;
        void'(bus_wait_q.pop_front());
      end
    end
  endtask

  task automatic drive_cycle(input int load_pct, input int halt_pct, input int kill_pct);
    @(negedge clk);
    ex_valid    = ($urandom_range(99) < 70);
    ex_lsu_en   = ($urandom_range(99) < load_pct);
    ex_rf_we    = ($urandom_range(99) < 85);
    ex_rf_waddr = REG_ADDR_W'($urandom_range(NUM_REGS - 1));
    ex_rf_wdata = $urandom;
    halt_wb     = ($urandom_range(99) < halt_pct);
    // Kill only a non-load in write-back
    kill_wb     = !halt_wb && slot_valid && !slot_load && ($urandom_range(99) < kill_pct);
    step_bus();
  endtask

  task automatic drive_idle();
    @(negedge clk);
    ex_valid = 1'b0;
    halt_wb  = 1'b0;
    kill_wb  = 1'b0;
    step_bus();
  endtask

  task automatic drain_pipe();
    drive_idle();
    while (slot_valid || bus_wait_q.size() != 0 || data_rvalid) begin
      drive_idle();
    end
  endtask

  task automatic finish_test();
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  task automatic run_random(input int id, input int load_pct, input int halt_pct,
                            input int kill_pct);
    test_id = id;
    repeat (OPS_PER_TEST) drive_cycle(load_pct, halt_pct, kill_pct);
    drain_pipe();
    finish_test();
  endtask

  task automatic sweep_regfile();
    test_id  = 6;
    readback = 1'b1;
    for (int a = 0; a < NUM_REGS; a++) begin
      @(negedge clk);
      rs_addr = REG_ADDR_W'(a);
    end
    @(negedge clk);
    readback = 1'b0;
    finish_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    ex_valid    = 1'b0;
    ex_rf_we    = 1'b0;
    ex_rf_waddr = '0;
    ex_rf_wdata = '0;
    ex_lsu_en   = 1'b0;
    kill_wb     = 1'b0;
    halt_wb     = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = '0;
    rs_addr     = '0;
    test_id     = 0;
    test_end    = 1'b0;
    readback    = 1'b0;
    run_done    = 1'b0;
    void'($urandom(SEED));
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    run_random(1, 0, 0, 0);
    run_random(2, 100, 0, 0);
    run_random(3, 40, 25, 0);
    run_random(4, 0, 0, 40);
    run_random(5, 50, 15, 20);
    sweep_regfile();
    @(negedge clk);
    run_done = 1'b1;
    @(negedge clk);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wb_sub.f ====
hdl/wb_pkg.sv
hdl/ex_wb_pipe_reg.sv
hdl/lsu_resp.sv
hdl/wb_stage.sv
hdl/reg_file.sv
hdl/wb_top.sv
tb/wb_top_sva.sv
tb/wb_checker.sv
tb/wb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the write-back testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module wb_tb -f wb_sub.f -o wb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
# An aborted run, such as a failed assertion, counts as a failure
./obj_dir/wb_sim > sim.log 2>&1 || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; } || exit 0
